//--- src/fpFormatPkg.sv
// binary16 number format: field widths, field types, operand classes, flags
// imported by every block that unpacks or builds half-precision values
package fpFormatPkg;

    // ------------------------------------------------------------------------
    // field geometry
    // ------------------------------------------------------------------------
    localparam int EXP_WIDTH  = 5;
    localparam int FRAC_WIDTH = 10;
    // stored fraction plus hidden bit
    localparam int SIG_WIDTH  = FRAC_WIDTH + 1;
    localparam int WORD_WIDTH = 1 + EXP_WIDTH + FRAC_WIDTH;

    // whole packed value, sign at the top
    typedef logic [WORD_WIDTH-1:0] halfWord;
    // biased exponent
    typedef logic [EXP_WIDTH-1:0]  expField;
    // stored fraction
    typedef logic [FRAC_WIDTH-1:0] fracField;
    // significand with hidden bit
    typedef logic [SIG_WIDTH-1:0]  sigField;

    // ------------------------------------------------------------------------
    // constants
    // ------------------------------------------------------------------------
    localparam int EXP_BIAS = 15;
    // all-ones exponent, reserved for inf and nan
    localparam expField EXP_MAX = '1;
    // quiet nan, positive sign, top fraction bit set
    localparam halfWord CANON_NAN = 16'h7E00;

    // operand class, decided once at issue time
    typedef enum logic [2:0] {
        opZero,
        opNormal,
        opSubnormal,
        opInfinity,
        opNan
    } opClass;

    // exception flags, one bit each
    typedef struct packed {
        logic overflow;
        logic underflow;
        logic inexact;
        logic invalid;
    } fpFlags;

endpackage

//--- src/mulStreamPkg.sv
// records that move between the issuer, the queue and the multiply pipe
// built from the binary16 field types
package mulStreamPkg;

    // ------------------------------------------------------------------------
    // one unpacked operand
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                sign;
        // subnormals already promoted to 1
        fpFormatPkg::expField exp;
        // hidden bit cleared for subnormals and zero
        fpFormatPkg::sigField sig;
        fpFormatPkg::opClass  cls;
    } opFields;

    // issued operand pair, one queue entry
    typedef struct packed {
        opFields a;
        opFields b;
    } issuedOps;

    // ------------------------------------------------------------------------
    // finished product leaving the pipe
    // ------------------------------------------------------------------------
    typedef struct packed {
        fpFormatPkg::halfWord product;
        fpFormatPkg::fpFlags  flags;
    } mulResult;

endpackage

//--- src/operandIssue.sv
// registers strobed operand pairs, classifies both operands and writes the queue
// strobes seen while the queue is full are dropped and counted
`timescale 1ns/1ps

module operandIssue (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inStrobe,
    input  fpFormatPkg::halfWord   opA,
    input  fpFormatPkg::halfWord   opB,
    input  logic                   full,
    output logic                   writeStrobe,
    output mulStreamPkg::issuedOps writeData,
    output logic [15:0]            dropCount
);
    import fpFormatPkg::*;
    import mulStreamPkg::*;

    // split one binary16 word and decide its class
    function automatic opFields unpackOperand(input halfWord value);
        expField  exp;
        fracField frac;
        opFields  fields;
        exp         = value[FRAC_WIDTH +: EXP_WIDTH];
        frac        = value[FRAC_WIDTH-1:0];
        fields.sign = value[WORD_WIDTH-1];
        fields.exp  = exp;
        fields.sig  = {1'b1, frac};
        if (exp == EXP_MAX) begin
            if (frac != '0) fields.cls = opNan;
            else fields.cls = opInfinity;
        end else if (exp == '0) begin
            // no hidden bit, exponent counts as 1
            fields.exp = expField'(1);
            fields.sig = {1'b0, frac};
            if (frac != '0) fields.cls = opSubnormal;
            else fields.cls = opZero;
        end else begin
            fields.cls = opNormal;
        end
        return fields;
    endfunction

    // ------------------------------------------------------------------------
    // strobe and drop accounting
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            writeStrobe <= 1'b0;
            dropCount   <= '0;
        end else begin
            // issue only if the queue had room when the strobe came
            writeStrobe <= inStrobe && !full;
            // saturate rather than wrap
            if (inStrobe && full && dropCount != 16'hFFFF) begin
                dropCount <= dropCount + 16'd1;
            end
        end
    end

    // payload, classified one cycle ahead of the write
    always_ff @(posedge clk) begin
        if (inStrobe) begin
            writeData.a <= unpackOperand(opA);
            writeData.b <= unpackOperand(opB);
        end
    end

endmodule

//--- src/operandQueue.sv
// synchronous FIFO of issued operand records, first-word-fall-through read
// depth is a power of two, full and empty come straight from flops
`timescale 1ns/1ps

module operandQueue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   writeStrobe,
    input  mulStreamPkg::issuedOps writeData,
    input  logic                   pop,
    output mulStreamPkg::issuedOps readData,
    output logic                   full,
    output logic                   empty
);
    import mulStreamPkg::*;

    // index bits plus one wrap bit
    localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);

    issuedOps             mem [QUEUE_DEPTH];
    logic [PTR_WIDTH:0]   wrPtr;
    logic [PTR_WIDTH:0]   rdPtr;
    logic [PTR_WIDTH:0]   wrPtrNext;
    logic [PTR_WIDTH:0]   rdPtrNext;
    logic                 doWrite;
    logic                 doRead;

    // ------------------------------------------------------------------------
    // pointer update
    // ------------------------------------------------------------------------
    assign doRead    = pop && !empty;
    // a pop in the same cycle frees the slot of a full queue
    assign doWrite   = writeStrobe && (!full || doRead);
    assign wrPtrNext = wrPtr + (PTR_WIDTH+1)'(doWrite);
    assign rdPtrNext = rdPtr + (PTR_WIDTH+1)'(doRead);

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            empty <= 1'b1;
            full  <= 1'b0;
        end else begin
            wrPtr <= wrPtrNext;
            rdPtr <= rdPtrNext;
            // same slot and same lap means nothing stored
            empty <= (wrPtrNext == rdPtrNext);
            // same slot, writer one lap ahead
            full  <= (wrPtrNext[PTR_WIDTH] != rdPtrNext[PTR_WIDTH]) &&
                     (wrPtrNext[PTR_WIDTH-1:0] == rdPtrNext[PTR_WIDTH-1:0]);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr[PTR_WIDTH-1:0]] <= writeData;
        end
    end

    // head entry is visible whenever empty is low
    assign readData = mem[rdPtr[PTR_WIDTH-1:0]];

endmodule

//--- src/halfMulPipe.sv
// three-stage binary16 multiply: specials and product, normalize, round and flags
// pops one queue record per cycle, result appears three cycles after pop
`timescale 1ns/1ps

module halfMulPipe (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   empty,
    input  mulStreamPkg::issuedOps readData,
    output logic                   pop,
    output logic                   outStrobe,
    output mulStreamPkg::mulResult result
);
    import fpFormatPkg::*;
    import mulStreamPkg::*;

    // 2.20 fixed-point significand product
    typedef logic [2*SIG_WIDTH-1:0] sigProduct;
    // signed exponent with room for shifts on both sides
    typedef logic signed [7:0]      expSum;

    typedef struct packed {
        logic      sign;
        logic      special;
        halfWord   specialWord;
        logic      invalid;
        sigProduct prod;
        // unbiased
        expSum     exp;
    } stageOne;

    typedef struct packed {
        logic    sign;
        logic    special;
        halfWord specialWord;
        logic    invalid;
        sigField sig;
        logic    guard;
        logic    sticky;
        expSum   exp;
    } stageTwo;

    stageOne   s1Next;
    stageOne   s1;
    stageTwo   s2Next;
    stageTwo   s2;
    mulResult  resultNext;
    logic      s1Valid;
    logic      s2Valid;
    sigProduct normProd;
    logic      shiftOut;
    logic [4:0] leadPos;
    logic [SIG_WIDTH:0] roundSum;
    logic      roundUp;
    expSum     roundExp;
    sigField   roundSig;

    // drain one record every cycle there is one
    assign pop = !empty;

    // ------------------------------------------------------------------------
    // stage 1: specials, significand product, exponent sum
    // ------------------------------------------------------------------------
    always_comb begin
        s1Next.sign        = readData.a.sign ^ readData.b.sign;
        s1Next.special     = 1'b1;
        s1Next.invalid     = 1'b0;
        s1Next.specialWord = {s1Next.sign, {(WORD_WIDTH-1){1'b0}}};
        if (readData.a.cls == opNan || readData.b.cls == opNan ||
            (readData.a.cls == opInfinity && readData.b.cls == opZero) ||
            (readData.a.cls == opZero && readData.b.cls == opInfinity)) begin
            s1Next.specialWord = CANON_NAN;
            s1Next.invalid     = 1'b1;
        end else if (readData.a.cls == opInfinity || readData.b.cls == opInfinity) begin
            s1Next.specialWord = {s1Next.sign, EXP_MAX, {FRAC_WIDTH{1'b0}}};
        end else if (readData.a.cls == opZero || readData.b.cls == opZero) begin
            // signed zero, already set above
            s1Next.special = 1'b1;
        end else begin
            s1Next.special = 1'b0;
        end
        s1Next.prod = readData.a.sig * readData.b.sig;
        s1Next.exp  = expSum'({3'b000, readData.a.exp}) + expSum'({3'b000, readData.b.exp}) -
                      expSum'(2 * EXP_BIAS);
    end

    // ------------------------------------------------------------------------
    // stage 2: bring the leading one to bit 20
    // ------------------------------------------------------------------------
    always_comb begin
        normProd = s1.prod;
        shiftOut = 1'b0;
        leadPos  = 5'd20;
        s2Next.exp = s1.exp;
        if (s1.prod[2*SIG_WIDTH-1]) begin
            // product in [2,4), one step right
            shiftOut   = s1.prod[0];
            normProd   = s1.prod >> 1;
            s2Next.exp = s1.exp + expSum'(1);
        end else begin
            // subnormal inputs leave the leading one low
            for (int i = 0; i <= 20; i++) begin
                if (s1.prod[i]) leadPos = 5'(i);
            end
            normProd   = s1.prod << (5'd20 - leadPos);
            s2Next.exp = s1.exp - expSum'({3'b000, 5'd20 - leadPos});
        end
        s2Next.sign        = s1.sign;
        s2Next.special     = s1.special;
        s2Next.specialWord = s1.specialWord;
        s2Next.invalid     = s1.invalid;
        s2Next.sig         = normProd[2*SIG_WIDTH-2 -: SIG_WIDTH];
        s2Next.guard       = normProd[FRAC_WIDTH-1];
        s2Next.sticky      = (|normProd[FRAC_WIDTH-2:0]) | shiftOut;
    end

    // ------------------------------------------------------------------------
    // stage 3: round to nearest even, range checks, flags
    // ------------------------------------------------------------------------
    always_comb begin
        // ties go to the even significand
        roundUp  = s2.guard && (s2.sticky || s2.sig[0]);
        roundSum = {1'b0, s2.sig} + (SIG_WIDTH+1)'(roundUp);
        roundSig = roundSum[SIG_WIDTH-1:0];
        roundExp = s2.exp + expSum'(EXP_BIAS);
        if (roundSum[SIG_WIDTH]) begin
            // carry out, significand is now 10.000..., shift back
            roundSig = roundSum[SIG_WIDTH:1];
            roundExp = roundExp + expSum'(1);
        end
        resultNext.flags = '0;
        if (s2.special) begin
            resultNext.product       = s2.specialWord;
            resultNext.flags.invalid = s2.invalid;
        end else if (roundExp >= expSum'(EXP_MAX)) begin
            resultNext.product         = {s2.sign, EXP_MAX, {FRAC_WIDTH{1'b0}}};
            resultNext.flags.overflow  = 1'b1;
            resultNext.flags.inexact   = 1'b1;
        end else if (roundExp <= expSum'(0)) begin
            // no subnormal outputs, flush to signed zero
            resultNext.product         = {s2.sign, {(WORD_WIDTH-1){1'b0}}};
            resultNext.flags.underflow = 1'b1;
            resultNext.flags.inexact   = |s2.sig;
        end else begin
            resultNext.product       = {s2.sign, expField'(roundExp), roundSig[FRAC_WIDTH-1:0]};
            resultNext.flags.inexact = s2.guard | s2.sticky;
        end
    end

    // valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            s1Valid   <= 1'b0;
            s2Valid   <= 1'b0;
            outStrobe <= 1'b0;
        end else begin
            s1Valid   <= pop;
            s2Valid   <= s1Valid;
            outStrobe <= s2Valid;
        end
    end

    // stage payloads
    always_ff @(posedge clk) begin
        s1     <= s1Next;
        s2     <= s2Next;
        result <= resultNext;
    end

endmodule

//--- src/halfMulUnit.sv
// top of the streaming binary16 multiplier: issuer, operand queue, multiply pipe
// queue depth is set here and handed to the queue
`timescale 1ns/1ps

module halfMulUnit #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inStrobe,
    input  fpFormatPkg::halfWord   opA,
    input  fpFormatPkg::halfWord   opB,
    output logic                   outStrobe,
    output mulStreamPkg::mulResult result,
    output logic                   queueFull,
    output logic [15:0]            dropCount
);
    import mulStreamPkg::*;

    // issuer to queue
    logic     writeStrobe;
    issuedOps writeData;
    // queue to pipe
    issuedOps readData;
    logic     queueEmpty;
    logic     pop;

    operandIssue issue0 (
        .clk         (clk),
        .reset       (reset),
        .inStrobe    (inStrobe),
        .opA         (opA),
        .opB         (opB),
        .full        (queueFull),
        .writeStrobe (writeStrobe),
        .writeData   (writeData),
        .dropCount   (dropCount)
    );

    operandQueue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue0 (
        .clk         (clk),
        .reset       (reset),
        .writeStrobe (writeStrobe),
        .writeData   (writeData),
        .pop         (pop),
        .readData    (readData),
        .full        (queueFull),
        .empty       (queueEmpty)
    );

    halfMulPipe pipe0 (
        .clk       (clk),
        .reset     (reset),
        .empty     (queueEmpty),
        .readData  (readData),
        .pop       (pop),
        .outStrobe (outStrobe),
        .result    (result)
    );

endmodule

//--- dv/halfMulChecker.sv
// concurrent assertions on the multiplier unit's strobes, queue levels and drop counter
// attached to every halfMulUnit by the bind at the bottom
`timescale 1ns/1ps

module halfMulChecker (
    input logic        clk,
    input logic        reset,
    input logic        inStrobe,
    input logic        queueFull,
    input logic        queueEmpty,
    input logic        outStrobe,
    input logic [15:0] dropCount
);
    // accepted requests still owed a result
    int unanswered;

    always @(posedge clk) begin
        if (reset) begin
            unanswered <= 0;
        end else if (inStrobe && !queueFull && !outStrobe) begin
            unanswered <= unanswered + 1;
        end else if (!(inStrobe && !queueFull) && outStrobe) begin
            unanswered <= unanswered - 1;
        end
    end

    // every result answers an earlier accepted strobe
    resultHasRequest: assert property (@(posedge clk) disable iff (reset)
        outStrobe |-> unanswered > 0)
        else $error("outStrobe with no accepted request outstanding");

    levelsExclusive: assert property (@(posedge clk) disable iff (reset)
        !(queueFull && queueEmpty))
        else $error("queue reports full and empty at once");

    // saturating counter, only ever climbs
    dropsMonotonic: assert property (@(posedge clk) disable iff (reset)
        dropCount >= $past(dropCount))
        else $error("dropCount went down");

endmodule

bind halfMulUnit halfMulChecker check0 (
    .clk        (clk),
    .reset      (reset),
    .inStrobe   (inStrobe),
    .queueFull  (queueFull),
    .queueEmpty (queueEmpty),
    .outStrobe  (outStrobe),
    .dropCount  (dropCount)
);

//--- dv/halfMulScoreboard.sv
// reference model and result checker for the binary16 multiplier unit
// watches the unit's ports, one expected result queued per accepted request
`timescale 1ns/1ps

module halfMulScoreboard #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inStrobe,
    input  fpFormatPkg::halfWord   opA,
    input  fpFormatPkg::halfWord   opB,
    input  logic                   queueFull,
    input  logic                   outStrobe,
    input  mulStreamPkg::mulResult result,
    input  logic [15:0]            dropCount,
    input  logic                   endOfTest,
    output int                     pending,
    output int                     mismatchErrors,
    output int                     otherErrors
);
    import mulStreamPkg::*;

    mulResult expectQ[$];
    mulResult want;
    int       dropsSeen;
    logic     endChecked;
    // queue occupancy expected from the issue and pop timing
    int       queueLevel;
    logic     writeDue;
    logic     modelFull;

    // product and flags worked out on plain integers
    function automatic mulResult expectedProduct(input logic [15:0] a, input logic [15:0] b);
        int       expA, expB;
        int       fracA, fracB;
        int       p, e;
        int       sig, guard;
        int       rest, sticky;
        logic     sign;
        mulResult r;
        r     = '0;
        sign  = a[15] ^ b[15];
        expA  = int'(a[14:10]);
        expB  = int'(b[14:10]);
        fracA = int'(a[9:0]);
        fracB = int'(b[9:0]);
        // any nan, or infinity against zero
        if ((expA == 31 && fracA != 0) || (expB == 31 && fracB != 0) ||
            (expA == 31 && expB == 0 && fracB == 0) ||
            (expB == 31 && expA == 0 && fracA == 0)) begin
            r.product       = 16'h7E00;
            r.flags.invalid = 1'b1;
        end else if (expA == 31 || expB == 31) begin
            r.product = {sign, 15'h7C00};
        end else if ((expA == 0 && fracA == 0) || (expB == 0 && fracB == 0)) begin
            r.product = {sign, 15'h0000};
        end else begin
            // subnormal: exponent 1, no hidden bit
            p      = (expA == 0 ? fracA : fracA + 1024) * (expB == 0 ? fracB : fracB + 1024);
            e      = (expA == 0 ? 1 : expA) + (expB == 0 ? 1 : expB) - 15;
            sticky = 0;
            // p has 20 fraction bits, bring it into [1,2)
            while (p >= (1 << 21)) begin
                sticky = sticky | (p & 1);
                p      = p >> 1;
                e      = e + 1;
            end
            while (p < (1 << 20)) begin
                p = p << 1;
                e = e - 1;
            end
            sig   = p >> 10;
            guard = (p >> 9) & 1;
            rest  = (p & 511) | sticky;
            // nearest, ties to even
            if (guard == 1 && (rest != 0 || sig % 2 == 1)) sig = sig + 1;
            if (sig == 2048) begin
                sig = sig >> 1;
                e   = e + 1;
            end
            if (e >= 31) begin
                r.product        = {sign, 15'h7C00};
                r.flags.overflow = 1'b1;
                r.flags.inexact  = 1'b1;
            end else if (e <= 0) begin
                r.product         = {sign, 15'h0000};
                r.flags.underflow = 1'b1;
                r.flags.inexact   = 1'b1;
            end else begin
                r.product       = {sign, 5'(e), 10'(sig)};
                r.flags.inexact = (guard != 0 || rest != 0);
            end
        end
        return r;
    endfunction

    task automatic compareField(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        if (expected !== actual) begin
            $display("Fail %s expected 0x%h got 0x%h", name, expected, actual);
            mismatchErrors = mismatchErrors + 1;
        end
    endtask

    // ------------------------------------------------------------------------
    // track requests, compare each result in arrival order
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            expectQ.delete();
            dropsSeen      = 0;
            mismatchErrors = 0;
            otherErrors    = 0;
            endChecked     = 1'b0;
            queueLevel     = 0;
            writeDue       = 1'b0;
        end else begin
            // full level left by the previous edge
            modelFull  = (queueLevel == QUEUE_DEPTH);
            compareField("queueFull", 16'(modelFull), 16'(queueFull));
            // write one cycle after acceptance, pop every cycle a record waits
            queueLevel = queueLevel + (writeDue ? 1 : 0) - (queueLevel != 0 ? 1 : 0);
            writeDue   = inStrobe && !modelFull;
            if (inStrobe && !queueFull) expectQ.push_back(expectedProduct(opA, opB));
            if (inStrobe && queueFull) dropsSeen = dropsSeen + 1;
            if (outStrobe && expectQ.size() == 0) begin
                $display("outStrobe arrived with no accepted request waiting for it");
                otherErrors = otherErrors + 1;
            end else if (outStrobe) begin
                want = expectQ.pop_front();
                compareField("result.product", want.product, result.product);
                compareField("result.flags.overflow", 16'(want.flags.overflow),
                             16'(result.flags.overflow));
                compareField("result.flags.underflow", 16'(want.flags.underflow),
                             16'(result.flags.underflow));
                compareField("result.flags.inexact", 16'(want.flags.inexact),
                             16'(result.flags.inexact));
                compareField("result.flags.invalid", 16'(want.flags.invalid),
                             16'(result.flags.invalid));
            end
            if (endOfTest && !endChecked) begin
                endChecked = 1'b1;
                if (expectQ.size() != 0) begin
                    $display("%0d accepted requests never produced a result", expectQ.size());
                    otherErrors = otherErrors + 1;
                end
                compareField("dropCount", 16'(dropsSeen), dropCount);
            end
        end
        pending <= expectQ.size();
    end

endmodule

//--- dv/halfMulTb.sv
// testbench for the binary16 multiplier unit: reset, latency, corner cases, random bursts
// top module of the simulation built from build.f
`timescale 1ns/1ps

module halfMulTb;
    import fpFormatPkg::*;
    import mulStreamPkg::*;

    localparam int QUEUE_DEPTH    = 8;
    localparam int TIMEOUT_CYCLES = 400;
    localparam int BURST_LENGTH   = 64;

    logic        clk;
    logic        reset;
    logic        inStrobe;
    halfWord     opA;
    halfWord     opB;
    logic        outStrobe;
    mulResult    result;
    logic        queueFull;
    logic [15:0] dropCount;
    logic        endOfTest;
    int          pending;
    int          mismatchErrors;
    int          otherErrors;
    int          tbErrors;
    logic [31:0] lcgState;

    halfMulUnit #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .inStrobe  (inStrobe),
        .opA       (opA),
        .opB       (opB),
        .outStrobe (outStrobe),
        .result    (result),
        .queueFull (queueFull),
        .dropCount (dropCount)
    );

    halfMulScoreboard #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) sb0 (
        .clk            (clk),
        .reset          (reset),
        .inStrobe       (inStrobe),
        .opA            (opA),
        .opB            (opB),
        .queueFull      (queueFull),
        .outStrobe      (outStrobe),
        .result         (result),
        .dropCount      (dropCount),
        .endOfTest      (endOfTest),
        .pending        (pending),
        .mismatchErrors (mismatchErrors),
        .otherErrors    (otherErrors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextLcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // exponent 12..18 from the upper, better mixed bits
    function automatic halfWord nearBias(input logic [31:0] r);
        logic [4:0] expo;
        expo = 5'd12 + (r[30:26] % 5'd7);
        return {r[31], expo, r[25:16]};
    endfunction

    task automatic sendPair(input halfWord a, input halfWord b);
        @(posedge clk);
        inStrobe <= 1'b1;
        opA      <= a;
        opB      <= b;
    endtask

    task automatic stopStrobe();
        @(posedge clk);
        inStrobe <= 1'b0;
    endtask

    task automatic waitForDrain();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (pending != 0 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (pending != 0) begin
            $display("timed out with %0d results still outstanding", pending);
            tbErrors++;
        end
    endtask

    // outStrobe must rise 5 clocks after inStrobe
    task automatic measureLatency(input halfWord a, input halfWord b);
        int cycles;
        cycles = 0;
        sendPair(a, b);
        @(negedge clk);
        while (!outStrobe && cycles < TIMEOUT_CYCLES) begin
            stopStrobe();
            @(negedge clk);
            cycles++;
        end
        if (!outStrobe) begin
            $display("isolated request never produced an outStrobe");
            tbErrors++;
        end else if (cycles != 5) begin
            $display("Fail outStrobe latency expected 0x%h got 0x%h", 5, cycles);
            tbErrors++;
        end
    endtask

    task automatic sendBurst(input bit nearBiasOnly);
        halfWord a;
        halfWord b;
        for (int i = 0; i < BURST_LENGTH; i++) begin
            lcgState = nextLcg(lcgState);
            a        = nearBiasOnly ? nearBias(lcgState) : lcgState[31:16];
            lcgState = nextLcg(lcgState);
            b        = nearBiasOnly ? nearBias(lcgState) : lcgState[31:16];
            sendPair(a, b);
        end
        stopStrobe();
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        reset     = 1'b1;
        inStrobe  = 1'b0;
        opA       = '0;
        opB       = '0;
        endOfTest = 1'b0;
        tbErrors  = 0;
        lcgState  = 32'h8564;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (outStrobe !== 1'b0) begin
                $display("outStrobe is not low after reset");
                tbErrors++;
            end
        end
        measureLatency(16'h3C00, 16'h4000);
        waitForDrain();
        // nan, inf times zero, signed inf and zero
        sendPair(16'h7C01, 16'h3C00);
        sendPair(16'h7C00, 16'h0000);
        sendPair(16'h8000, 16'hFC00);
        sendPair(16'hFC00, 16'h4000);
        sendPair(16'h8000, 16'h4000);
        sendPair(16'hC000, 16'h4200);
        // ties: odd rounds up, even stays
        sendPair(16'h3C01, 16'h3E00);
        sendPair(16'h3C03, 16'h3E00);
        sendPair(16'h3BFF, 16'h3C01);
        // overflow, underflow, subnormal inputs
        sendPair(16'h7BFF, 16'h4000);
        sendPair(16'h7BFF, 16'h3C01);
        sendPair(16'h0400, 16'h0400);
        sendPair(16'h0001, 16'h3C00);
        sendPair(16'h03FF, 16'h4000);
        stopStrobe();
        waitForDrain();
        sendBurst(1'b1);
        waitForDrain();
        sendBurst(1'b0);
        waitForDrain();
        @(posedge clk);
        endOfTest <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        $display("errors: mismatches %0d, protocol %0d, testbench %0d",
                 mismatchErrors, otherErrors, tbErrors);
        if (mismatchErrors + otherErrors + tbErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- build.f
src/fpFormatPkg.sv
src/mulStreamPkg.sv
src/operandIssue.sv
src/operandQueue.sv
src/halfMulPipe.sv
src/halfMulUnit.sv
dv/halfMulChecker.sv
dv/halfMulScoreboard.sv
dv/halfMulTb.sv

//--- run.sh
#!/bin/sh
# compile the multiplier testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module halfMulTb -o halfMulSim
output=$(./obj_dir/halfMulSim) || true
echo "$output"
if echo "$output" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1
